// ==== build.f ====
verilog/video_pkg.sv
verilog/dpram.sv
verilog/video_timing.sv
verilog/gfx_rom_arbiter.sv
verilog/bg_scanline.sv
verilog/sprite_scanline.sv
verilog/color_mixer.sv
verilog/tile_video.sv
testbench/tile_video_props.sv
testbench/tile_video_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the tile video testbench with Verilator

if ! verilator --binary --timing --assert -f build.f --top-module tile_video_tb \
        --Mdir obj_dir -o tile_video_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tile_video_sim > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error status"
    exit 1
fi

cat sim.log

if grep -q "^TEST OK$" sim.log; then
    exit 0
fi

echo "Pass message not found in sim.log"
exit 1

// ==== testbench/tile_video_props.sv ====
// Bound twice with unused ports tied off; fires only after reset is released
`timescale 1ns/1ps

module tile_video_props (
    input logic       clk,
    input logic       arst_n,
    input logic       valid_a,
    input logic       valid_b,
    input logic       rom_en,
    input logic       blank,
    input logic [7:0] pout
);

    // ROM read port serves one peer per cycle
    one_valid_a: assert property (@(posedge clk) disable iff (!arst_n)
        !(valid_a && valid_b))
        else $error("ROM data returned to both peers in the same cycle");

    // A download cycle must not have granted a read
    no_grant_in_download_a: assert property (@(posedge clk) disable iff (!arst_n)
        rom_en |=> !(valid_a || valid_b))
        else $error("ROM read granted while a download write was active");

    // Dark from one pixel period after blanking starts
    blank_zero_a: assert property (@(posedge clk) disable iff (!arst_n)
        (blank && $past(blank, 8)) |-> (pout == 8'd0))
        else $error("Pixel output not zero during blanking");

endmodule

bind gfx_rom_arbiter tile_video_props arb_props_inst (
    .clk    (VCLKx8),
    .arst_n (arst_n),
    .valid_a(bg_valid),
    .valid_b(spr_valid),
    .rom_en (rom_en),
    .blank  (1'b0),
    .pout   (8'd0)
);

bind color_mixer tile_video_props mix_props_inst (
    .clk    (VCLKx8),
    .arst_n (arst_n),
    .valid_a(1'b0),
    .valid_b(1'b0),
    .rom_en (rom_en),
    .blank  (hblank),
    .pout   (pout)
);

// ==== testbench/tile_video_tb.sv ====
// Checks visible columns 0 to 273 of whole frames; counts 1 to 16 of each line are not checked
`timescale 1ns/1ps

module tile_video_tb
    import video_pkg::*;
;

    localparam int frame_cycles   = 384 * 264 * 8;
    localparam int download_bytes = 8192 + 256 + 32;
    // Five test frames, up to two frames of alignment, the download and reset
    localparam int timeout_cycles = 7 * frame_cycles + download_bytes + 200;

    logic        VCLKx8;
    logic        arst_n;
    logic [15:0] vram_d;
    logic [27:0] spra_d;
    logic [7:0]  scroll;
    logic        flip_screen;
    logic [16:0] rom_ad;
    logic [7:0]  rom_dt;
    logic        rom_en;
    logic [9:0]  vram_a;
    logic [2:0]  spra_a;
    logic [7:0]  pout;
    logic        vblank;
    logic        pix_en;

    // Memory models and ROM images
    logic [15:0] vram     [0:1023];
    logic [27:0] spr_ram  [0:7];
    logic [27:0] spr_line [0:7];
    logic [7:0]  gfx_mem  [0:8191];
    logic [3:0]  clut_mem [0:255];
    logic [7:0]  pal_mem  [0:31];

    // Raster position and state as the DUT sees it
    int         h_cnt;
    int         v_cnt;
    int         pix_gap;
    logic [7:0] ref_scroll;
    logic [2:0] flip_hist;
    logic       checking;
    int         pass_cnt;
    int         fail_cnt;
    int         cycle_cnt;
    event       frame_start;

    tile_video tile_video_inst (
        .VCLKx8     (VCLKx8),
        .arst_n     (arst_n),
        .vram_d     (vram_d),
        .spra_d     (spra_d),
        .scroll     (scroll),
        .flip_screen(flip_screen),
        .rom_ad     (rom_ad),
        .rom_dt     (rom_dt),
        .rom_en     (rom_en),
        .vram_a     (vram_a),
        .spra_a     (spra_a),
        .pout       (pout),
        .vblank     (vblank),
        .pix_en     (pix_en)
    );

    assign vram_d = vram[vram_a];
    assign spra_d = spr_ram[spra_a];

    always #5 VCLKx8 = ~VCLKx8;

    // --------------------
    // Expected colour for one visible column
    function automatic logic [7:0] expected_pixel(input int line, input int col,
                                                  input logic flip, input logic [7:0] scr);
        int          hp;
        int          yl;
        int          ys;
        int          k;
        int          dx;
        int          dy;
        logic [15:0] tile;
        logic [7:0]  pat;
        logic [1:0]  pix;
        logic [1:0]  sval;
        logic [3:0]  bcol;
        logic [3:0]  scol;
        logic        svalid;
        logic [4:0]  idx;
        hp   = flip ? 287 - col : col;
        yl   = flip ? 255 - (line % 256) : line % 256;
        ys   = (yl + int'(scr)) % 256;
        tile = vram[(ys / 8) * 32 + (hp / 8) % 32];
        pat  = gfx_mem[int'(tile[7:0]) * 16 + ((hp / 4) % 2) * 8 + ys % 8];
        k    = hp % 4;
        pix  = {pat[7 - k], pat[3 - k]};
        bcol = clut_mem[int'(tile[13:8]) * 4 + int'(pix)];
        // Lowest entry with a non-zero pixel owns the column
        svalid = 1'b0;
        scol   = 4'd0;
        for (int e = 0; e < 8; e++) begin
            dy = (line - int'(spr_line[e][27:19]) + 512) % 512;
            dx = (col - int'(spr_line[e][18:10]) + 512) % 512;
            if (!svalid && dy < 8 && dx < 8) begin
                pat  = gfx_mem[4096 + int'(spr_line[e][7:0]) * 16 + (dx / 4) * 8 + dy];
                k    = dx % 4;
                sval = {pat[7 - k], pat[3 - k]};
                if (sval != 2'd0) begin
                    svalid = 1'b1;
                    scol   = {spr_line[e][9:8], sval};
                end
            end
        end
        if ((tile[14] && bcol != 4'd15) || !svalid || scol == 4'd15) begin
            idx = {1'b1, bcol};
        end else begin
            idx = {1'b0, scol};
        end
        return pal_mem[idx];
    endfunction

    task automatic check_value(input logic [7:0] got, input logic [7:0] exp,
                               input string what);
        if (got !== exp) begin
            fail_cnt++;
            $display("Error at time %0t: %s on line %0d count %0d, got %h expected %h",
                     $time, what, v_cnt, h_cnt, got, exp);
        end else begin
            pass_cnt++;
        end
    endtask

    // --------------------
    // Compare process, one step per pixel period
    always @(negedge VCLKx8) begin
        if (!arst_n) begin
            h_cnt      = 0;
            v_cnt      = 0;
            pix_gap    = 0;
            ref_scroll = 8'd0;
            flip_hist  = 3'd0;
            for (int e = 0; e < 8; e++) begin
                spr_line[e] = spr_ram[e];
            end
        end else if (pix_en) begin
            if (checking) begin
                // One pixel per eight clocks
                check_value(8'(pix_gap), 8'd7, "pixel enable spacing");
                // Column c leaves the mixer during count c + 17
                if (h_cnt >= 17 && h_cnt <= 290) begin
                    check_value(pout, expected_pixel(v_cnt, h_cnt - 17, flip_hist[2],
                                ref_scroll), "pixel");
                end else if (h_cnt > 290 || h_cnt == 0) begin
                    check_value(pout, 8'd0, "blanked pixel");
                end
                if (h_cnt == 0) begin
                    check_value({7'd0, vblank}, {7'd0, v_cnt == 227}, "vblank");
                end
            end
            // Scroll and sprite list for the next line are taken here
            if (h_cnt == 290) begin
                ref_scroll = scroll;
                for (int e = 0; e < 8; e++) begin
                    spr_line[e] = spr_ram[e];
                end
            end
            flip_hist = {flip_hist[1:0], flip_screen};
            pix_gap   = 0;
            if (h_cnt == 383) begin
                h_cnt = 0;
                v_cnt = (v_cnt == 263) ? 0 : v_cnt + 1;
            end else begin
                h_cnt++;
            end
            if (h_cnt == 0 && v_cnt == 0) begin
                -> frame_start;
            end
        end else begin
            pix_gap++;
        end
    end

    always @(posedge VCLKx8) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("Timeout: the tests did not finish within %0d clock cycles",
                     timeout_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // --------------------
    // Stimulus helpers
    task automatic rom_write(input logic [16:0] addr, input logic [7:0] data);
        @(negedge VCLKx8);
        rom_ad = addr;
        rom_dt = data;
        rom_en = 1'b1;
    endtask

    task automatic download_roms();
        for (int i = 0; i < 8192; i++) begin
            rom_write(rom_gfx_base + 17'(i), gfx_mem[i]);
        end
        // Upper nibble is not stored by the lookup table
        for (int i = 0; i < 256; i++) begin
            rom_write(rom_clut_base + 17'(i), {4'($urandom), clut_mem[i]});
        end
        for (int i = 0; i < 32; i++) begin
            rom_write(rom_pal_base + 17'(i), pal_mem[i]);
        end
        @(negedge VCLKx8);
        rom_en = 1'b0;
    endtask

    task automatic place_sprites();
        int sx;
        int sy;
        for (int e = 0; e < 8; e++) begin
            sy = 30 + 3 * e;
            sx = (e == 6) ? 508 : (e == 7) ? 268 : 60 + 3 * e;
            spr_ram[e] = {9'(sy), 9'(sx), 2'($urandom), 8'($urandom)};
        end
    endtask

    // Runs one whole frame and reports its checks
    task automatic run_frame(input string name);
        int f0;
        int n0;
        f0 = fail_cnt;
        n0 = pass_cnt + fail_cnt;
        @(frame_start);
        $display("%s: %0d checks, %0d errors", name, pass_cnt + fail_cnt - n0, fail_cnt - f0);
        @(negedge VCLKx8);
    endtask

    initial begin
        int seed_ret;
        seed_ret    = $urandom(32'hd5a9);
        VCLKx8      = 1'b0;
        arst_n      = 1'b0;
        scroll      = 8'd0;
        flip_screen = 1'b0;
        rom_ad      = 17'd0;
        rom_dt      = 8'd0;
        rom_en      = 1'b0;
        checking    = 1'b0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        for (int i = 0; i < 1024; i++) begin
            vram[i] = 16'($urandom);
        end
        for (int i = 0; i < 8192; i++) begin
            gfx_mem[i] = 8'($urandom);
        end
        for (int i = 0; i < 256; i++) begin
            clut_mem[i] = 4'($urandom);
        end
        for (int i = 0; i < 32; i++) begin
            pal_mem[i] = 8'($urandom);
        end
        // y of 300 keeps every sprite off the raster
        for (int e = 0; e < 8; e++) begin
            spr_ram[e] = {9'd300, 9'(e * 20), 2'd0, 8'(e)};
        end
        repeat (10) @(negedge VCLKx8);
        arst_n = 1'b1;
        download_roms();
        @(frame_start);
        @(negedge VCLKx8);
        checking = 1'b1;
        run_frame("background only");
        scroll = 8'($urandom);
        run_frame("vertical scroll");
        flip_screen = 1'b1;
        run_frame("flip screen");
        flip_screen = 1'b0;
        place_sprites();
        run_frame("sprites and priority");
        flip_screen = 1'b1;
        scroll      = 8'($urandom);
        run_frame("blanking and vblank");
        $display("%0d checks passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/bg_scanline.sv ====
// Tile columns 32 to 35 repeat columns 0 to 3; scroll is 8 bits and flip mirrors a 288 x 256 map
`timescale 1ns/1ps

module bg_scanline
    import video_pkg::*;
(
    input  logic                  VCLKx8,
    input  logic                  arst_n,
    input  logic                  pix_en,
    input  logic [8:0]            ph,
    input  logic [8:0]            pv,
    input  logic [7:0]            scroll,
    input  logic                  flip_screen,
    input  logic [15:0]           vram_d,
    input  logic [7:0]            bg_data,
    input  logic                  bg_valid,
    output logic [9:0]            vram_a,
    output logic                  bg_req,
    output logic [gfx_addr_w-1:0] bg_addr,
    output logic [1:0]            bg_pixel,
    output logic [5:0]            bg_pal,
    output logic                  bg_hi
);

    logic [7:0] scroll_lat;
    logic [8:0] col_n;
    logic [8:0] hp;
    logic [7:0] yl;
    logic [7:0] ys;
    logic [7:0] t_code;
    logic [5:0] t_pal;
    logic       t_hi;
    logic       t_half;
    logic [1:0] t_pix;
    logic [2:0] t_row;
    logic [7:0] pat;

    // Scroll takes effect from the next line
    always_ff @(posedge VCLKx8 or negedge arst_n) begin
        if (!arst_n) begin
            scroll_lat <= 8'd0;
        end else if (pix_en && ph == scroll_latch_h) begin
            scroll_lat <= scroll;
        end
    end

    // --------------------
    // Tile stage, two pixels ahead of display
    assign col_n  = ph - (h_offset - 9'd2);
    assign hp     = flip_screen ? (h_active - 9'd1 - col_n) : col_n;
    assign yl     = flip_screen ? ~pv[7:0] : pv[7:0];
    assign ys     = yl + scroll_lat;
    assign vram_a = {ys[7:3], hp[7:3]};

    always_ff @(posedge VCLKx8) begin
        if (pix_en) begin
            t_code <= vram_d[7:0];
            t_pal  <= vram_d[13:8];
            t_hi   <= vram_d[14];
            t_half <= hp[2];
            t_pix  <= hp[1:0];
            t_row  <= ys[2:0];
        end
    end

    // --------------------
    // Pattern fetch, one byte per pixel
    assign bg_addr = {1'b0, t_code, t_half, t_row};

    always_ff @(posedge VCLKx8 or negedge arst_n) begin
        if (!arst_n) begin
            bg_req <= 1'b0;
        end else if (pix_en) begin
            bg_req <= 1'b1;
        end else if (bg_valid) begin
            bg_req <= 1'b0;
        end
    end

    always_ff @(posedge VCLKx8) begin
        if (bg_valid) begin
            pat <= bg_data;
        end
    end

    // Pixel out at the start of its display count
    always_ff @(posedge VCLKx8 or negedge arst_n) begin
        if (!arst_n) begin
            bg_pixel <= 2'd0;
            bg_pal   <= 6'd0;
            bg_hi    <= 1'b0;
        end else if (pix_en) begin
            bg_pixel <= pat_pixel(pat, t_pix);
            bg_pal   <= t_pal;
            bg_hi    <= t_hi;
        end
    end

endmodule

// ==== verilog/color_mixer.sv ====
// Output is forced to zero in horizontal blanking only; vertical blanking is left to the display
`timescale 1ns/1ps

module color_mixer
    import video_pkg::*;
(
    input  logic        VCLKx8,
    input  logic        arst_n,
    input  logic        pix_en,
    input  logic        hblank,
    input  logic [1:0]  bg_pixel,
    input  logic [5:0]  bg_pal,
    input  logic        bg_hi,
    input  logic [4:0]  spr_col,
    input  logic [16:0] rom_ad,
    input  logic [7:0]  rom_dt,
    input  logic        rom_en,
    output logic [7:0]  pout
);

    logic [clut_addr_w-1:0] clut_a;
    logic [3:0]             clut_q;
    logic                   clut_we;
    logic [pal_addr_w-1:0]  pal_idx;
    logic [7:0]             pal_q;
    logic                   pal_we;
    logic                   bg_win;
    logic                   blank_d;

    assign clut_a  = {bg_pal, bg_pixel};
    assign clut_we = rom_en && (rom_ad[16:clut_addr_w] == rom_clut_base[16:clut_addr_w]);
    assign pal_we  = rom_en && (rom_ad[16:pal_addr_w] == rom_pal_base[16:pal_addr_w]);

    dpram #(
        .word_t(logic [3:0]),
        .addr_w(clut_addr_w)
    ) clut_inst (
        .clk_a (VCLKx8),
        .addr_a(clut_a),
        .q_a   (clut_q),
        .clk_b (VCLKx8),
        .addr_b(rom_ad[clut_addr_w-1:0]),
        .we_b  (clut_we),
        .d_b   (rom_dt[3:0])
    );

    // Colour 15 and a clear valid flag are both transparent
    assign bg_win = (bg_hi && clut_q != 4'd15) || !spr_col[4] || (spr_col[3:0] == 4'd15);

    always_ff @(posedge VCLKx8 or negedge arst_n) begin
        if (!arst_n) begin
            pal_idx <= '0;
            blank_d <= 1'b1;
        end else if (pix_en) begin
            pal_idx <= bg_win ? {1'b1, clut_q} : {1'b0, spr_col[3:0]};
            blank_d <= hblank;
        end
    end

    dpram #(
        .word_t(logic [7:0]),
        .addr_w(pal_addr_w)
    ) pal_inst (
        .clk_a (VCLKx8),
        .addr_a(pal_idx),
        .q_a   (pal_q),
        .clk_b (VCLKx8),
        .addr_b(rom_ad[pal_addr_w-1:0]),
        .we_b  (pal_we),
        .d_b   (rom_dt)
    );

    assign pout = blank_d ? 8'd0 : pal_q;

endmodule

// ==== verilog/dpram.sv ====
// Contents start undefined; port a reads with one cycle of latency and port b only writes
`timescale 1ns/1ps

module dpram #(
    parameter type word_t = logic [7:0],
    parameter int  addr_w = 8
) (
    input  logic              clk_a,
    input  logic [addr_w-1:0] addr_a,
    output word_t             q_a,
    input  logic              clk_b,
    input  logic [addr_w-1:0] addr_b,
    input  logic              we_b,
    input  word_t             d_b
);

    word_t mem [0:(1<<addr_w)-1];

    always_ff @(posedge clk_a) begin
        q_a <= mem[addr_a];
    end

    // Download or line buffer writes
    always_ff @(posedge clk_b) begin
        if (we_b) begin
            mem[addr_b] <= d_b;
        end
    end

endmodule

// ==== verilog/gfx_rom_arbiter.sv ====
// Reads pause during any ROM download, and each peer is served only in its own sub-cycle slot
`timescale 1ns/1ps

module gfx_rom_arbiter
    import video_pkg::*;
(
    input  logic                  VCLKx8,
    input  logic                  arst_n,
    input  logic [2:0]            sub_cycle,
    input  logic                  bg_req,
    input  logic [gfx_addr_w-1:0] bg_addr,
    input  logic                  spr_req,
    input  logic [gfx_addr_w-1:0] spr_addr,
    input  logic [16:0]           rom_ad,
    input  logic [7:0]            rom_dt,
    input  logic                  rom_en,
    output logic [7:0]            bg_data,
    output logic                  bg_valid,
    output logic [7:0]            spr_data,
    output logic                  spr_valid
);

    logic                  gfx_we;
    logic                  grant_bg;
    logic                  grant_spr;
    logic [gfx_addr_w-1:0] rd_addr;
    logic [7:0]            rom_q;

    assign gfx_we = rom_en && (rom_ad[16:gfx_addr_w] == rom_gfx_base[16:gfx_addr_w]);

    // Download has priority, peers only in their slot
    assign grant_bg  = bg_req && !rom_en && (sub_cycle == slot_bg);
    assign grant_spr = spr_req && !rom_en && (sub_cycle == slot_spr);
    assign rd_addr   = (sub_cycle == slot_spr) ? spr_addr : bg_addr;

    dpram #(
        .word_t(logic [7:0]),
        .addr_w(gfx_addr_w)
    ) gfx_rom_inst (
        .clk_a (VCLKx8),
        .addr_a(rd_addr),
        .q_a   (rom_q),
        .clk_b (VCLKx8),
        .addr_b(rom_ad[gfx_addr_w-1:0]),
        .we_b  (gfx_we),
        .d_b   (rom_dt)
    );

    // Byte returns one cycle after the grant
    always_ff @(posedge VCLKx8 or negedge arst_n) begin
        if (!arst_n) begin
            bg_valid  <= 1'b0;
            spr_valid <= 1'b0;
        end else begin
            bg_valid  <= grant_bg;
            spr_valid <= grant_spr;
        end
    end

    assign bg_data  = bg_valid ? rom_q : 8'd0;
    assign spr_data = spr_valid ? rom_q : 8'd0;

endmodule

// ==== verilog/sprite_scanline.sv ====
// Eight 8x8 sprites without flip; the hblank fill must finish before count 15 of the next line
`timescale 1ns/1ps

module sprite_scanline
    import video_pkg::*;
(
    input  logic                  VCLKx8,
    input  logic                  arst_n,
    input  logic                  pix_en,
    input  logic [8:0]            ph,
    input  logic [8:0]            pv,
    input  logic                  hblank,
    input  logic [spr_attr_w-1:0] spra_d,
    input  logic [7:0]            spr_data,
    input  logic                  spr_valid,
    output logic [spr_idx_w-1:0]  spra_a,
    output logic                  spr_req,
    output logic [gfx_addr_w-1:0] spr_addr,
    output logic [4:0]            spr_col
);

    typedef enum logic [1:0] {st_idle, st_scan, st_fetch, st_write} state_t;

    state_t               state;
    logic                 hblank_q;
    logic [8:0]           tgt_line;
    logic [8:0]           y_diff;
    logic [spr_idx_w-1:0] idx;
    logic [7:0]           s_code;
    logic [1:0]           s_pal;
    logic [8:0]           s_x;
    logic [2:0]           s_row;
    logic                 half;
    logic [15:0]          pat;
    logic [2:0]           wpix;
    logic [1:0]           wval;
    logic [8:0]           rd_col;
    logic                 rd_win;
    logic [4:0]           lb_q;
    logic [8:0]           lb_wa;
    logic                 lb_we;
    logic [4:0]           lb_wd;

    assign spra_a   = idx;
    assign y_diff   = tgt_line - spra_d[27:19];
    assign spr_req  = (state == st_fetch);
    assign spr_addr = {1'b1, s_code, half, s_row};

    // --------------------
    // Highest entry first so entry 0 is drawn last and wins
    always_ff @(posedge VCLKx8 or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            hblank_q <= 1'b0;
            tgt_line <= 9'd0;
            idx      <= '0;
            half     <= 1'b0;
            wpix     <= 3'd0;
        end else begin
            hblank_q <= hblank;
            case (state)
                st_idle: begin
                    if (hblank && !hblank_q) begin
                        tgt_line <= (pv == v_total - 9'd1) ? 9'd0 : pv + 9'd1;
                        idx      <= spr_idx_w'(sprite_count - 1);
                        state    <= st_scan;
                    end
                end
                st_scan: begin
                    if (y_diff[8:3] == 6'd0) begin
                        half  <= 1'b0;
                        state <= st_fetch;
                    end else if (idx == '0) begin
                        state <= st_idle;
                    end else begin
                        idx <= idx - spr_idx_w'(1);
                    end
                end
                st_fetch: begin
                    if (spr_valid) begin
                        half <= 1'b1;
                        if (half) begin
                            wpix  <= 3'd0;
                            state <= st_write;
                        end
                    end
                end
                default: begin
                    wpix <= wpix + 3'd1;
                    if (wpix == 3'd7) begin
                        if (idx == '0) begin
                            state <= st_idle;
                        end else begin
                            idx   <= idx - spr_idx_w'(1);
                            state <= st_scan;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge VCLKx8) begin
        if (state == st_scan) begin
            s_code <= spra_d[7:0];
            s_pal  <= spra_d[9:8];
            s_x    <= spra_d[18:10];
            s_row  <= y_diff[2:0];
        end
        if (state == st_fetch && spr_valid) begin
            if (half) begin
                pat[7:0] <= spr_data;
            end else begin
                pat[15:8] <= spr_data;
            end
        end
    end

    // --------------------
    // Line buffer, read one pixel ahead and cleared behind
    assign rd_col = ph - (h_offset - 9'd1);
    assign rd_win = (ph >= h_offset - 9'd1) && (ph < h_blank_start - 9'd1);
    assign wval   = pat_pixel(wpix[2] ? pat[7:0] : pat[15:8], wpix[1:0]);

    always_comb begin
        if (state == st_write) begin
            lb_wa = s_x + {6'd0, wpix};
            lb_we = (wval != 2'd0);
            lb_wd = {1'b1, s_pal, wval};
        end else begin
            lb_wa = rd_col;
            lb_we = pix_en && rd_win;
            lb_wd = 5'd0;
        end
    end

    dpram #(
        .word_t(logic [4:0]),
        .addr_w(lbuf_addr_w)
    ) lbuf_inst (
        .clk_a (VCLKx8),
        .addr_a(rd_col),
        .q_a   (lb_q),
        .clk_b (VCLKx8),
        .addr_b(lb_wa),
        .we_b  (lb_we),
        .d_b   (lb_wd)
    );

    always_ff @(posedge VCLKx8 or negedge arst_n) begin
        if (!arst_n) begin
            spr_col <= 5'd0;
        end else if (pix_en) begin
            spr_col <= rd_win ? lb_q : 5'd0;
        end
    end

endmodule

// ==== verilog/tile_video.sv ====
// External VRAM and sprite attribute RAM must answer vram_a and spra_a in the same cycle
`timescale 1ns/1ps

module tile_video
    import video_pkg::*;
(
    input  logic                  VCLKx8,
    input  logic                  arst_n,
    input  logic [15:0]           vram_d,
    input  logic [spr_attr_w-1:0] spra_d,
    input  logic [7:0]            scroll,
    input  logic                  flip_screen,
    input  logic [16:0]           rom_ad,
    input  logic [7:0]            rom_dt,
    input  logic                  rom_en,
    output logic [9:0]            vram_a,
    output logic [spr_idx_w-1:0]  spra_a,
    output logic [7:0]            pout,
    output logic                  vblank,
    output logic                  pix_en
);

    // Raster
    logic [8:0] ph;
    logic [8:0] pv;
    logic [2:0] sub_cycle;
    logic       hblank;

    // Graphics ROM peers
    logic                  bg_req;
    logic [gfx_addr_w-1:0] bg_addr;
    logic [7:0]            bg_data;
    logic                  bg_valid;
    logic                  spr_req;
    logic [gfx_addr_w-1:0] spr_addr;
    logic [7:0]            spr_data;
    logic                  spr_valid;

    // Into the mixer
    logic [1:0] bg_pixel;
    logic [5:0] bg_pal;
    logic       bg_hi;
    logic [4:0] spr_col;

    // Port names match across units
    video_timing timing_inst (.*);

    gfx_rom_arbiter arbiter_inst (.*);

    bg_scanline bg_inst (.*);

    sprite_scanline sprite_inst (.*);

    color_mixer mixer_inst (.*);

endmodule

// ==== verilog/video_pkg.sv ====
// One memory layout only; counts assume a 384 x 264 raster at one pixel per 8 VCLKx8 cycles
package video_pkg;

    // --------------------
    // Raster timing
    localparam logic [8:0] h_total        = 9'd384;
    localparam logic [8:0] h_offset       = 9'd16;
    localparam logic [8:0] h_active       = 9'd288;
    localparam logic [8:0] h_blank_start  = 9'd290;
    localparam logic [8:0] h_blank_end    = 9'd492;
    localparam logic [8:0] v_total        = 9'd264;
    localparam logic [8:0] v_blank_line   = 9'd227;
    localparam logic [8:0] scroll_latch_h = 9'd290;

    // --------------------
    // Download map, 17-bit byte addresses
    localparam logic [16:0] rom_gfx_base  = 17'h12000;
    localparam logic [16:0] rom_clut_base = 17'h14000;
    localparam logic [16:0] rom_pal_base  = 17'h14100;

    // Memory and attribute widths
    localparam int gfx_addr_w   = 13;
    localparam int clut_addr_w  = 8;
    localparam int pal_addr_w   = 5;
    localparam int lbuf_addr_w  = 9;
    localparam int sprite_count = 8;
    localparam int spr_idx_w    = 3;
    // Sprite attribute {y[8:0], x[8:0], pal[1:0], code[7:0]}
    localparam int spr_attr_w   = 28;

    // ROM slots within the pixel period
    localparam logic [2:0] slot_bg  = 3'd0;
    localparam logic [2:0] slot_spr = 3'd4;

    // Pixel k of a pattern byte takes one bit from each nibble, leftmost first
    function automatic logic [1:0] pat_pixel(input logic [7:0] pat, input logic [1:0] k);
        case (k)
            2'd0:    pat_pixel = {pat[7], pat[3]};
            2'd1:    pat_pixel = {pat[6], pat[2]};
            2'd2:    pat_pixel = {pat[5], pat[1]};
            default: pat_pixel = {pat[4], pat[0]};
        endcase
    endfunction

endpackage

// ==== verilog/video_timing.sv ====
// Fixed 384 x 264 raster that free-runs from reset; there is no external sync input
`timescale 1ns/1ps

module video_timing
    import video_pkg::*;
(
    input  logic       VCLKx8,
    input  logic       arst_n,
    output logic [8:0] ph,
    output logic [8:0] pv,
    output logic [2:0] sub_cycle,
    output logic       pix_en,
    output logic       hblank,
    output logic       vblank
);

    // Last sub-cycle of each pixel period
    assign pix_en = (sub_cycle == 3'd7);

    always_ff @(posedge VCLKx8 or negedge arst_n) begin
        if (!arst_n) begin
            sub_cycle <= 3'd0;
            ph        <= 9'd0;
            pv        <= 9'd0;
        end else begin
            sub_cycle <= sub_cycle + 3'd1;
            if (pix_en) begin
                if (ph == h_total - 9'd1) begin
                    ph <= 9'd0;
                    pv <= (pv == v_total - 9'd1) ? 9'd0 : pv + 9'd1;
                end else begin
                    ph <= ph + 9'd1;
                end
            end
        end
    end

    // Blank end lies past h_total so blanking runs to the end of the line
    assign hblank = (ph >= h_blank_start) && (ph < h_blank_end);
    assign vblank = (pv == v_blank_line);

endmodule
